// ==== rtl/isolate_pkg.sv ====
////////////////////////////////////////////////////////////
// isolation gate package
// AXI field widths, pending capacity, counter width and
// the state encoding shared by both channel gates
////////////////////////////////////////////////////////////
`default_nettype none

package isolate_pkg;

  // open transactions per channel before handshakes are cut
  localparam int unsigned NUM_PENDING = 4;
  // room for zero up to twice the capacity (atomic injection)
  localparam int unsigned CNT_W = $clog2(2 * NUM_PENDING + 1);

  // AXI field widths
  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ATOP_W = 6;

  // atop bit: atomic expects a read response
  localparam int unsigned ATOP_R_RESP = 5;

  typedef logic [ID_W-1:0]   id_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ATOP_W-1:0] atop_t;
  typedef logic [1:0]        resp_t;  // OKAY/EXOKAY/SLVERR/DECERR
  typedef logic [CNT_W-1:0]  cnt_t;   // pending counters

  // per channel gate FSM
  typedef enum logic [1:0] {
    GATE_NORMAL,   // pass-through
    GATE_HOLD,     // stalled address kept valid
    GATE_DRAIN,    // no new addresses, wait for responses
    GATE_ISOLATE   // master side silenced
  } gate_state_e;

endpackage

`default_nettype wire

// ==== rtl/track_if.sv ====
////////////////////////////////////////////////////////////
// tracking interface
// strobes and levels from the gates to the tracker, open
// read count back to both gates
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface track_if;

  logic               ar_inject;    // accepted AW is an atomic with read response
  logic               ar_accept;    // AR passed forward in NORMAL
  logic               aw_isolated;  // write gate in ISOLATE
  logic               ar_isolated;  // read gate in ISOLATE
  isolate_pkg::cnt_t  pending_ar;   // open reads incl. injected atomics

  modport wr (
    output ar_inject,
    output aw_isolated,
    input  pending_ar
  );

  modport rd (
    output ar_accept,
    output ar_isolated,
    input  pending_ar
  );

  modport trk (
    input  ar_inject,
    input  ar_accept,
    input  aw_isolated,
    input  ar_isolated,
    output pending_ar
  );

endinterface

`default_nettype wire

// ==== rtl/write_gate.sv ====
////////////////////////////////////////////////////////////
// write channel gate
// passes AW/W/B through, counts open writes and W bursts,
// cuts handshakes at capacity and drains on isolate_i
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module write_gate (
  input  logic               clk_i,
  input  logic               reset_i,
  // AW
  input  logic               slv_aw_valid_i,
  input  isolate_pkg::id_t   slv_aw_id_i,
  input  isolate_pkg::addr_t slv_aw_addr_i,
  input  isolate_pkg::atop_t slv_aw_atop_i,
  output logic               slv_aw_ready_o,
  output logic               mst_aw_valid_o,
  output isolate_pkg::id_t   mst_aw_id_o,
  output isolate_pkg::addr_t mst_aw_addr_o,
  output isolate_pkg::atop_t mst_aw_atop_o,
  input  logic               mst_aw_ready_i,
  // W
  input  logic               slv_w_valid_i,
  input  isolate_pkg::data_t slv_w_data_i,
  input  logic               slv_w_last_i,
  output logic               slv_w_ready_o,
  output logic               mst_w_valid_o,
  output isolate_pkg::data_t mst_w_data_o,
  output logic               mst_w_last_o,
  input  logic               mst_w_ready_i,
  // B
  input  logic               mst_b_valid_i,
  input  isolate_pkg::id_t   mst_b_id_i,
  input  isolate_pkg::resp_t mst_b_resp_i,
  output logic               mst_b_ready_o,
  output logic               slv_b_valid_o,
  output isolate_pkg::id_t   slv_b_id_o,
  output isolate_pkg::resp_t slv_b_resp_o,
  input  logic               slv_b_ready_i,
  input  logic               isolate_i,
  track_if.wr                trk
);

  isolate_pkg::gate_state_e aw_state_q, aw_state_d;
  isolate_pkg::cnt_t        pending_aw_q, pending_aw_d;  // open write bursts (until B)
  isolate_pkg::cnt_t        pending_w_q, pending_w_d;    // W bursts without last beat
  logic                     aw_full;
  logic                     aw_issue;   // AW counted this cycle and unlocks W
  logic                     w_last_hs;
  logic                     b_hs;

  // AW cut when any write count or the shared read count is full
  assign aw_full = (pending_aw_q >= isolate_pkg::cnt_t'(isolate_pkg::NUM_PENDING))
                || (pending_w_q >= isolate_pkg::cnt_t'(isolate_pkg::NUM_PENDING))
                || (trk.pending_ar >= isolate_pkg::cnt_t'(2 * isolate_pkg::NUM_PENDING));

  assign aw_issue  = mst_aw_valid_o && (aw_state_q == isolate_pkg::GATE_NORMAL);
  assign w_last_hs = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;
  assign b_hs      = mst_b_valid_i && mst_b_ready_o;

  ////////////////////////////////////////////////////////////
  // AW / B gating and write FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    aw_state_d     = aw_state_q;
    mst_aw_valid_o = slv_aw_valid_i;  // straight through by default
    mst_aw_id_o    = slv_aw_id_i;
    mst_aw_addr_o  = slv_aw_addr_i;
    mst_aw_atop_o  = slv_aw_atop_i;
    slv_aw_ready_o = mst_aw_ready_i;
    slv_b_valid_o  = mst_b_valid_i;
    slv_b_id_o     = mst_b_id_i;
    slv_b_resp_o   = mst_b_resp_i;
    mst_b_ready_o  = slv_b_ready_i;
    unique case (aw_state_q)
      isolate_pkg::GATE_NORMAL: begin
        if (aw_full) begin
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b0;
          if (isolate_i) aw_state_d = isolate_pkg::GATE_DRAIN;
        end else if (slv_aw_valid_i && !mst_aw_ready_i) begin
          aw_state_d = isolate_pkg::GATE_HOLD;  // already counted so keep it valid
        end else if (isolate_i) begin
          aw_state_d = isolate_pkg::GATE_DRAIN;
        end
      end
      isolate_pkg::GATE_HOLD: begin
        mst_aw_valid_o = 1'b1;  // must not drop once offered
        if (mst_aw_ready_i) begin
          aw_state_d = isolate_i ? isolate_pkg::GATE_DRAIN : isolate_pkg::GATE_NORMAL;
        end
      end
      isolate_pkg::GATE_DRAIN: begin
        mst_aw_valid_o = 1'b0;
        mst_aw_id_o    = '0;
        mst_aw_addr_o  = '0;
        mst_aw_atop_o  = '0;
        slv_aw_ready_o = 1'b0;
        if (pending_aw_q == '0) aw_state_d = isolate_pkg::GATE_ISOLATE;  // last B seen
      end
      isolate_pkg::GATE_ISOLATE: begin
        mst_aw_valid_o = 1'b0;
        mst_aw_id_o    = '0;
        mst_aw_addr_o  = '0;
        mst_aw_atop_o  = '0;
        slv_aw_ready_o = 1'b0;
        slv_b_valid_o  = 1'b0;
        slv_b_id_o     = '0;
        slv_b_resp_o   = '0;
        mst_b_ready_o  = 1'b0;
        if (!isolate_i) aw_state_d = isolate_pkg::GATE_NORMAL;
      end
      default: aw_state_d = isolate_pkg::GATE_ISOLATE;
    endcase
  end

  // W only while a burst is open or its AW goes out now
  always_comb begin
    mst_w_valid_o = slv_w_valid_i;
    mst_w_data_o  = slv_w_data_i;
    mst_w_last_o  = slv_w_last_i;
    slv_w_ready_o = mst_w_ready_i;
    if ((pending_w_q == '0) && !aw_issue) begin
      mst_w_valid_o = 1'b0;
      mst_w_data_o  = '0;
      mst_w_last_o  = 1'b0;
      slv_w_ready_o = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////
  always_comb begin
    pending_aw_d = pending_aw_q;
    pending_w_d  = pending_w_q;
    if (aw_issue) begin
      pending_aw_d = pending_aw_d + isolate_pkg::cnt_t'(1);
      pending_w_d  = pending_w_d + isolate_pkg::cnt_t'(1);
    end
    if (b_hs)      pending_aw_d = pending_aw_d - isolate_pkg::cnt_t'(1);
    if (w_last_hs) pending_w_d  = pending_w_d - isolate_pkg::cnt_t'(1);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_state_q   <= isolate_pkg::GATE_ISOLATE;  // closed until isolate_i drops
      pending_aw_q <= '0;
      pending_w_q  <= '0;
    end else begin
      aw_state_q   <= aw_state_d;
      pending_aw_q <= pending_aw_d;
      pending_w_q  <= pending_w_d;
    end
  end

  assign trk.ar_inject   = aw_issue && mst_aw_atop_o[isolate_pkg::ATOP_R_RESP];
  assign trk.aw_isolated = (aw_state_q == isolate_pkg::GATE_ISOLATE);

  // count never passes capacity since AW is cut when full
  aw_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_aw_q >= isolate_pkg::cnt_t'(isolate_pkg::NUM_PENDING))
    |=> (pending_aw_q <= isolate_pkg::cnt_t'(isolate_pkg::NUM_PENDING)))
    else $error("write count above capacity");
  aw_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_aw_q == '0) |=> (pending_aw_q != '1))
    else $error("write count underflow");
  w_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_w_q == '0) |=> (pending_w_q != '1))
    else $error("W burst count underflow");

endmodule

`default_nettype wire

// ==== rtl/read_gate.sv ====
////////////////////////////////////////////////////////////
// read channel gate
// passes AR/R through, cuts AR at capacity, drains open
// reads on isolate_i and silences AR/R once isolated
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module read_gate (
  input  logic               clk_i,
  input  logic               reset_i,
  // AR
  input  logic               slv_ar_valid_i,
  input  isolate_pkg::id_t   slv_ar_id_i,
  input  isolate_pkg::addr_t slv_ar_addr_i,
  output logic               slv_ar_ready_o,
  output logic               mst_ar_valid_o,
  output isolate_pkg::id_t   mst_ar_id_o,
  output isolate_pkg::addr_t mst_ar_addr_o,
  input  logic               mst_ar_ready_i,
  // R
  input  logic               mst_r_valid_i,
  input  isolate_pkg::id_t   mst_r_id_i,
  input  isolate_pkg::data_t mst_r_data_i,
  input  isolate_pkg::resp_t mst_r_resp_i,
  input  logic               mst_r_last_i,
  output logic               mst_r_ready_o,
  output logic               slv_r_valid_o,
  output isolate_pkg::id_t   slv_r_id_o,
  output isolate_pkg::data_t slv_r_data_o,
  output isolate_pkg::resp_t slv_r_resp_o,
  output logic               slv_r_last_o,
  input  logic               slv_r_ready_i,
  input  logic               isolate_i,
  track_if.rd                trk
);

  isolate_pkg::gate_state_e ar_state_q, ar_state_d;
  logic                     ar_full;

  assign ar_full = trk.pending_ar >= isolate_pkg::cnt_t'(isolate_pkg::NUM_PENDING);

  always_comb begin
    ar_state_d     = ar_state_q;
    mst_ar_valid_o = slv_ar_valid_i;  // pass-through default
    mst_ar_id_o    = slv_ar_id_i;
    mst_ar_addr_o  = slv_ar_addr_i;
    slv_ar_ready_o = mst_ar_ready_i;
    slv_r_valid_o  = mst_r_valid_i;
    slv_r_id_o     = mst_r_id_i;
    slv_r_data_o   = mst_r_data_i;
    slv_r_resp_o   = mst_r_resp_i;
    slv_r_last_o   = mst_r_last_i;
    mst_r_ready_o  = slv_r_ready_i;
    unique case (ar_state_q)
      isolate_pkg::GATE_NORMAL: begin
        if (ar_full) begin
          mst_ar_valid_o = 1'b0;
          slv_ar_ready_o = 1'b0;
          if (isolate_i) ar_state_d = isolate_pkg::GATE_DRAIN;
        end else if (slv_ar_valid_i && !mst_ar_ready_i) begin
          ar_state_d = isolate_pkg::GATE_HOLD;
        end else if (isolate_i) begin
          ar_state_d = isolate_pkg::GATE_DRAIN;
        end
      end
      isolate_pkg::GATE_HOLD: begin
        mst_ar_valid_o = 1'b1;
        if (mst_ar_ready_i) begin
          ar_state_d = isolate_i ? isolate_pkg::GATE_DRAIN : isolate_pkg::GATE_NORMAL;
        end
      end
      isolate_pkg::GATE_DRAIN: begin
        mst_ar_valid_o = 1'b0;
        mst_ar_id_o    = '0;
        mst_ar_addr_o  = '0;
        slv_ar_ready_o = 1'b0;
        // atomics with read response count here too
        if (trk.pending_ar == '0) ar_state_d = isolate_pkg::GATE_ISOLATE;
      end
      isolate_pkg::GATE_ISOLATE: begin
        mst_ar_valid_o = 1'b0;
        mst_ar_id_o    = '0;
        mst_ar_addr_o  = '0;
        slv_ar_ready_o = 1'b0;
        slv_r_valid_o  = 1'b0;
        slv_r_id_o     = '0;
        slv_r_data_o   = '0;
        slv_r_resp_o   = '0;
        slv_r_last_o   = 1'b0;
        mst_r_ready_o  = 1'b0;
        if (!isolate_i) ar_state_d = isolate_pkg::GATE_NORMAL;
      end
      default: ar_state_d = isolate_pkg::GATE_ISOLATE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) ar_state_q <= isolate_pkg::GATE_ISOLATE;
    else         ar_state_q <= ar_state_d;
  end

  assign trk.ar_accept   = mst_ar_valid_o && (ar_state_q == isolate_pkg::GATE_NORMAL);
  assign trk.ar_isolated = (ar_state_q == isolate_pkg::GATE_ISOLATE);

  // stalled AR keeps valid high until the master takes it
  ar_hold_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=> mst_ar_valid_o)
    else $error("stalled AR dropped valid");

endmodule

`default_nettype wire

// ==== rtl/isolation_tracker.sv ====
////////////////////////////////////////////////////////////
// isolation tracker
// shared open read count fed by AR and atomic AW, and the
// combined isolated flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module isolation_tracker (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  r_valid_i,  // master side
  input  logic  r_ready_i,  // slave side
  input  logic  r_last_i,
  track_if.trk  trk,
  output logic  isolated_o
);

  isolate_pkg::cnt_t pending_ar_q, pending_ar_d;
  logic              r_last_hs;

  assign r_last_hs = r_valid_i && r_ready_i && r_last_i;

  // AR and atomic in one cycle add two
  always_comb begin
    pending_ar_d = pending_ar_q
                 + isolate_pkg::cnt_t'(trk.ar_accept)
                 + isolate_pkg::cnt_t'(trk.ar_inject);
    if (r_last_hs) pending_ar_d = pending_ar_d - isolate_pkg::cnt_t'(1);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) pending_ar_q <= '0;
    else         pending_ar_q <= pending_ar_d;
  end

  assign trk.pending_ar = pending_ar_q;
  assign isolated_o     = trk.aw_isolated && trk.ar_isolated;  // both gates closed

  // AR cut at NUM_PENDING and AW cut at twice that keep the count in range
  ar_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_ar_q >= isolate_pkg::cnt_t'(2 * isolate_pkg::NUM_PENDING))
    |=> (pending_ar_q <= isolate_pkg::cnt_t'(2 * isolate_pkg::NUM_PENDING)))
    else $error("read count above capacity");
  ar_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_ar_q == '0) |=> (pending_ar_q != '1))
    else $error("read count underflow");

endmodule

`default_nettype wire

// ==== rtl/axi_isolate_top.sv ====
////////////////////////////////////////////////////////////
// AXI isolation gate top
// write and read gates side by side with the tracker,
// plain AXI ports on both sides
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_isolate_top (
  input  logic               clk_i,
  input  logic               reset_i,
  // slave port
  input  logic               slv_aw_valid_i,
  input  isolate_pkg::id_t   slv_aw_id_i,
  input  isolate_pkg::addr_t slv_aw_addr_i,
  input  isolate_pkg::atop_t slv_aw_atop_i,
  output logic               slv_aw_ready_o,
  input  logic               slv_w_valid_i,
  input  isolate_pkg::data_t slv_w_data_i,
  input  logic               slv_w_last_i,
  output logic               slv_w_ready_o,
  output logic               slv_b_valid_o,
  output isolate_pkg::id_t   slv_b_id_o,
  output isolate_pkg::resp_t slv_b_resp_o,
  input  logic               slv_b_ready_i,
  input  logic               slv_ar_valid_i,
  input  isolate_pkg::id_t   slv_ar_id_i,
  input  isolate_pkg::addr_t slv_ar_addr_i,
  output logic               slv_ar_ready_o,
  output logic               slv_r_valid_o,
  output isolate_pkg::id_t   slv_r_id_o,
  output isolate_pkg::data_t slv_r_data_o,
  output isolate_pkg::resp_t slv_r_resp_o,
  output logic               slv_r_last_o,
  input  logic               slv_r_ready_i,
  // master port
  output logic               mst_aw_valid_o,
  output isolate_pkg::id_t   mst_aw_id_o,
  output isolate_pkg::addr_t mst_aw_addr_o,
  output isolate_pkg::atop_t mst_aw_atop_o,
  input  logic               mst_aw_ready_i,
  output logic               mst_w_valid_o,
  output isolate_pkg::data_t mst_w_data_o,
  output logic               mst_w_last_o,
  input  logic               mst_w_ready_i,
  input  logic               mst_b_valid_i,
  input  isolate_pkg::id_t   mst_b_id_i,
  input  isolate_pkg::resp_t mst_b_resp_i,
  output logic               mst_b_ready_o,
  output logic               mst_ar_valid_o,
  output isolate_pkg::id_t   mst_ar_id_o,
  output isolate_pkg::addr_t mst_ar_addr_o,
  input  logic               mst_ar_ready_i,
  input  logic               mst_r_valid_i,
  input  isolate_pkg::id_t   mst_r_id_i,
  input  isolate_pkg::data_t mst_r_data_i,
  input  isolate_pkg::resp_t mst_r_resp_i,
  input  logic               mst_r_last_i,
  output logic               mst_r_ready_o,
  // isolation control
  input  logic               isolate_i,
  output logic               isolated_o
);

  track_if track ();  // counts and states between gates and tracker

  // port names match the top level one to one
  write_gate u_write_gate (
    .*,
    .trk (track.wr)
  );

  read_gate u_read_gate (
    .*,
    .trk (track.rd)
  );

  isolation_tracker u_isolation_tracker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .r_valid_i  (mst_r_valid_i),
    .r_ready_i  (slv_r_ready_i),   // forwarded by read gate when not isolated
    .r_last_i   (mst_r_last_i),
    .trk        (track.trk),
    .isolated_o (isolated_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_axi_isolate.sv ====
////////////////////////////////////////////////////////////
// AXI isolation gate testbench
// replays steps from the stimulus file and checks outputs
// against a model of both gate FSMs and the pending counts
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_axi_isolate;

  localparam int NUM = int'(isolate_pkg::NUM_PENDING);

  // DUT ports named as on the top level
  logic               clk_i = 1'b0;
  logic               reset_i, isolate_i, isolated_o;
  logic               slv_aw_valid_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_ready_i;
  logic               slv_w_valid_i, slv_w_last_i, slv_w_ready_o;
  logic               mst_w_valid_o, mst_w_last_o, mst_w_ready_i;
  logic               mst_b_valid_i, mst_b_ready_o, slv_b_valid_o, slv_b_ready_i;
  logic               slv_ar_valid_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic               mst_r_valid_i, mst_r_last_i, mst_r_ready_o;
  logic               slv_r_valid_o, slv_r_last_o, slv_r_ready_i;
  isolate_pkg::id_t   slv_aw_id_i, mst_aw_id_o, mst_b_id_i, slv_b_id_o;
  isolate_pkg::id_t   slv_ar_id_i, mst_ar_id_o, mst_r_id_i, slv_r_id_o;
  isolate_pkg::addr_t slv_aw_addr_i, mst_aw_addr_o, slv_ar_addr_i, mst_ar_addr_o;
  isolate_pkg::atop_t slv_aw_atop_i, mst_aw_atop_o;
  isolate_pkg::data_t slv_w_data_i, mst_w_data_o, mst_r_data_i, slv_r_data_o;
  isolate_pkg::resp_t mst_b_resp_i, slv_b_resp_o, mst_r_resp_i, slv_r_resp_o;

  string                    steps[$];      // raw stimulus lines
  isolate_pkg::gate_state_e ws, rs;        // model write / read state
  int                       paw, pw, par;  // model open writes, W bursts, reads
  int                       tst, exp_iso;
  int                       cur_test = 0;
  int                       num_tests = 0;
  int                       errors = 0;
  int                       test_errors = 0;
  int unsigned              cycle_cnt = 0;
  int unsigned              cycle_limit = 50;

  axi_isolate_top u_axi_isolate_top (.*);

  always #5 clk_i = ~clk_i;  // 10 ns period

  // run limit armed from the step count
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_steps();
    int    fd;
    string line;
    fd = $fopen("verif/isolate_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/isolate_testdata.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // blank or column note
      steps.push_back(line);
    end
    $fclose(fd);
    cycle_limit = 2 * steps.size() + 50;
  endtask

  // one line of the file onto the DUT inputs
  task automatic apply_step(input string line, input int idx);
    int f[18];
    int n;
    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
    if (n != 18) begin
      $display("malformed stimulus line %0d: %s", idx, line);
      errors++;
    end
    tst            = f[0];
    slv_aw_valid_i = (f[1] != 0);
    slv_aw_id_i    = isolate_pkg::id_t'(f[2]);
    slv_aw_addr_i  = isolate_pkg::addr_t'(f[3]);
    slv_aw_atop_i  = isolate_pkg::atop_t'(f[4]);
    slv_w_valid_i  = (f[5] != 0);
    slv_w_last_i   = (f[6] != 0);
    slv_w_data_i   = isolate_pkg::data_t'(32'hd000_0000 | idx);  // data tagged by step
    slv_ar_valid_i = (f[7] != 0);
    slv_ar_id_i    = isolate_pkg::id_t'(f[8]);
    slv_ar_addr_i  = isolate_pkg::addr_t'(f[9]);
    mst_aw_ready_i = (f[10] != 0);
    mst_w_ready_i  = (f[11] != 0);
    mst_b_valid_i  = (f[12] != 0);
    mst_ar_ready_i = (f[13] != 0);
    mst_r_valid_i  = (f[14] != 0);
    mst_r_last_i   = (f[15] != 0);
    isolate_i      = (f[16] != 0);
    exp_iso        = f[17];
    mst_b_id_i     = isolate_pkg::id_t'(idx);
    mst_b_resp_i   = isolate_pkg::resp_t'(idx);
    mst_r_id_i     = isolate_pkg::id_t'(idx);
    mst_r_data_i   = isolate_pkg::data_t'(32'h5a00_0000 | idx);
    mst_r_resp_i   = isolate_pkg::resp_t'(idx + 1);
    // slave readies drop only on idle response cycles
    slv_b_ready_i  = mst_b_valid_i || (idx % 2 == 1);
    slv_r_ready_i  = mst_r_valid_i || (idx % 2 == 1);
  endtask

  // same transition rules on both channels
  function automatic isolate_pkg::gate_state_e next_state(
    input isolate_pkg::gate_state_e cur, input logic full, input logic valid,
    input logic ready, input logic empty, input logic iso);
    next_state = cur;
    case (cur)
      isolate_pkg::GATE_NORMAL: begin
        if (!full && valid && !ready) next_state = isolate_pkg::GATE_HOLD;  // stalled address
        else if (iso) next_state = isolate_pkg::GATE_DRAIN;
      end
      isolate_pkg::GATE_HOLD: begin
        if (ready) next_state = iso ? isolate_pkg::GATE_DRAIN : isolate_pkg::GATE_NORMAL;
      end
      isolate_pkg::GATE_DRAIN: if (empty) next_state = isolate_pkg::GATE_ISOLATE;
      default: if (!iso) next_state = isolate_pkg::GATE_NORMAL;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // model prediction, checks, then model update
  ////////////////////////////////////////////////////////////
  task automatic check_and_advance();
    logic        w_full, r_full, aw_issue, ar_acc, w_open, closed_w, closed_r;
    logic        b_pass, r_pass;
    logic        e_awv, e_awr, e_arv, e_arr, e_wv, e_wr, e_bready, e_iso;
    logic [31:0] e_awaddr, e_atop, e_araddr;
    isolate_pkg::gate_state_e ws_n, rs_n;
    w_full   = (paw >= NUM) || (pw >= NUM) || (par >= 2 * NUM);
    r_full   = (par >= NUM);
    closed_w = (ws == isolate_pkg::GATE_DRAIN) || (ws == isolate_pkg::GATE_ISOLATE);
    closed_r = (rs == isolate_pkg::GATE_DRAIN) || (rs == isolate_pkg::GATE_ISOLATE);
    b_pass   = (ws != isolate_pkg::GATE_ISOLATE);
    r_pass   = (rs != isolate_pkg::GATE_ISOLATE);
    // AW side
    e_awv    = (ws == isolate_pkg::GATE_HOLD) ? 1'b1 : slv_aw_valid_i;
    e_awr    = mst_aw_ready_i;
    e_awaddr = closed_w ? '0 : slv_aw_addr_i;
    e_atop   = closed_w ? '0 : 32'(slv_aw_atop_i);
    if (closed_w || (ws == isolate_pkg::GATE_NORMAL && w_full)) begin
      e_awv = 1'b0;
      e_awr = 1'b0;
    end
    aw_issue = e_awv && (ws == isolate_pkg::GATE_NORMAL);
    w_open   = (pw != 0) || aw_issue;  // W needs an open burst
    e_wv     = w_open && slv_w_valid_i;
    e_wr     = w_open && mst_w_ready_i;
    e_bready = b_pass && slv_b_ready_i;
    // AR side
    e_arv    = (rs == isolate_pkg::GATE_HOLD) ? 1'b1 : slv_ar_valid_i;
    e_arr    = mst_ar_ready_i;
    e_araddr = closed_r ? '0 : slv_ar_addr_i;
    if (closed_r || (rs == isolate_pkg::GATE_NORMAL && r_full)) begin
      e_arv = 1'b0;
      e_arr = 1'b0;
    end
    ar_acc = e_arv && (rs == isolate_pkg::GATE_NORMAL);
    e_iso  = (ws == isolate_pkg::GATE_ISOLATE) && (rs == isolate_pkg::GATE_ISOLATE);

    check_value("isolated_o", e_iso, isolated_o);
    check_value("isolated_o vs data file", exp_iso, isolated_o);
    check_value("mst_aw_valid_o", e_awv, mst_aw_valid_o);
    check_value("slv_aw_ready_o", e_awr, slv_aw_ready_o);
    check_value("mst_aw_id_o", closed_w ? '0 : slv_aw_id_i, mst_aw_id_o);
    check_value("mst_aw_addr_o", e_awaddr, mst_aw_addr_o);
    check_value("mst_aw_atop_o", e_atop, mst_aw_atop_o);
    check_value("mst_w_valid_o", e_wv, mst_w_valid_o);
    check_value("slv_w_ready_o", e_wr, slv_w_ready_o);
    check_value("mst_w_data_o", w_open ? slv_w_data_i : '0, mst_w_data_o);
    check_value("mst_w_last_o", w_open && slv_w_last_i, mst_w_last_o);
    check_value("slv_b_valid_o", b_pass && mst_b_valid_i, slv_b_valid_o);
    check_value("slv_b_id_o", b_pass ? mst_b_id_i : '0, slv_b_id_o);
    check_value("slv_b_resp_o", b_pass ? mst_b_resp_i : '0, slv_b_resp_o);
    check_value("mst_b_ready_o", e_bready, mst_b_ready_o);
    check_value("mst_ar_valid_o", e_arv, mst_ar_valid_o);
    check_value("slv_ar_ready_o", e_arr, slv_ar_ready_o);
    check_value("mst_ar_id_o", closed_r ? '0 : slv_ar_id_i, mst_ar_id_o);
    check_value("mst_ar_addr_o", e_araddr, mst_ar_addr_o);
    check_value("slv_r_valid_o", r_pass && mst_r_valid_i, slv_r_valid_o);
    check_value("slv_r_id_o", r_pass ? mst_r_id_i : '0, slv_r_id_o);
    check_value("slv_r_data_o", r_pass ? mst_r_data_i : '0, slv_r_data_o);
    check_value("slv_r_resp_o", r_pass ? mst_r_resp_i : '0, slv_r_resp_o);
    check_value("slv_r_last_o", r_pass && mst_r_last_i, slv_r_last_o);
    check_value("mst_r_ready_o", r_pass && slv_r_ready_i, mst_r_ready_o);

    // next states see the counts before this edge
    ws_n = next_state(ws, w_full, slv_aw_valid_i, mst_aw_ready_i, paw == 0, isolate_i);
    rs_n = next_state(rs, r_full, slv_ar_valid_i, mst_ar_ready_i, par == 0, isolate_i);
    paw  = paw + int'(aw_issue) - int'(mst_b_valid_i && e_bready);
    pw   = pw + int'(aw_issue) - int'(e_wv && mst_w_ready_i && slv_w_last_i);
    par  = par + int'(ar_acc) + int'(aw_issue && slv_aw_atop_i[isolate_pkg::ATOP_R_RESP])
         - int'(mst_r_valid_i && slv_r_ready_i && mst_r_last_i);  // tracker sees raw R
    ws   = ws_n;
    rs   = rs_n;
  endtask

  task automatic report_test();
    $display("test %0d finished with %0d errors", cur_test, test_errors);
  endtask

  initial begin
    reset_i        = 1'b1;
    isolate_i      = 1'b1;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_atop_i  = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_b_ready_i  = 1'b1;  // slave side takes every offered response
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_r_ready_i  = 1'b1;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    ws  = isolate_pkg::GATE_ISOLATE;  // both gates closed out of reset
    rs  = isolate_pkg::GATE_ISOLATE;
    paw = 0;
    pw  = 0;
    par = 0;
    load_steps();
    if (steps.size() == 0) begin
      $display("no stimulus steps loaded");
      errors++;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    foreach (steps[i]) begin
      apply_step(steps[i], i);
      if (tst != cur_test) begin
        if (cur_test != 0) report_test();
        cur_test    = tst;
        test_errors = 0;
        num_tests++;
      end
      #1;  // outputs settle well before the next edge
      check_and_advance();
      @(negedge clk_i);
    end
    if (cur_test != 0) report_test();
    $display("%0d tests, %0d steps, %0d errors", num_tests, steps.size(), errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/isolate_testdata.txt ====
# test aw_v aw_id aw_addr aw_atop w_v w_last ar_v ar_id ar_addr aw_rdy w_rdy b_v ar_rdy r_v r_last iso exp_iso
# test number decimal, all other columns hex; one line per clock cycle
1 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 1 1
1 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 0 1
1 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 0 0
2 1 3 1000 0  1 1 1 5 2000 1 1 0 1 0 0 0 0
2 0 0 0    0  0 0 0 0 0    0 0 1 0 1 1 0 0
3 1 1 1100 0  0 0 0 0 0    1 0 0 0 0 0 0 0
3 1 2 1200 0  0 0 0 0 0    1 0 0 0 0 0 0 0
3 1 3 1300 0  0 0 0 0 0    1 0 0 0 0 0 0 0
3 1 4 1400 0  0 0 0 0 0    1 0 0 0 0 0 0 0
3 1 5 1500 0  0 0 0 0 0    1 0 0 0 0 0 0 0
3 0 0 0    0  1 1 0 0 0    0 1 1 0 0 0 0 0
3 1 6 1600 0  0 0 0 0 0    1 0 0 0 0 0 0 0
3 0 0 0    0  1 1 1 7 2100 0 1 1 1 0 0 0 0
3 0 0 0    0  1 1 1 8 2200 0 1 1 1 0 0 0 0
3 0 0 0    0  1 1 1 9 2300 0 1 1 1 0 0 0 0
3 0 0 0    0  1 1 1 a 2400 0 1 1 1 0 0 0 0
3 0 0 0    0  0 0 1 b 2500 0 0 0 1 0 0 0 0
3 0 0 0    0  0 0 0 0 0    0 0 0 0 1 1 0 0
3 0 0 0    0  0 0 1 c 2600 0 0 0 1 0 0 0 0
4 0 0 0    0  1 1 0 0 0    0 1 0 0 0 0 0 0
5 1 9 3000 0  0 0 0 0 0    0 0 0 0 0 0 1 0
5 1 9 3000 0  1 1 0 0 0    1 1 0 0 0 0 1 0
5 0 0 0    0  0 0 0 0 0    0 0 0 0 1 1 1 0
5 0 0 0    0  0 0 0 0 0    0 0 1 0 1 1 1 0
5 0 0 0    0  0 0 0 0 0    0 0 0 0 1 1 1 0
5 0 0 0    0  0 0 0 0 0    0 0 0 0 1 1 1 0
5 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 1 0
5 1 a 4000 0  1 1 1 d 4100 1 1 0 1 0 0 1 1
6 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 0 1
6 1 e 5000 20 1 1 0 0 0    1 1 0 0 0 0 0 0
6 0 0 0    0  0 0 0 0 0    0 0 1 0 0 0 1 0
6 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 1 0
6 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 1 0
6 0 0 0    0  0 0 0 0 0    0 0 0 0 1 1 1 0
6 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 1 0
6 0 0 0    0  0 0 0 0 0    0 0 0 0 0 0 1 1

// ==== sources.f ====
rtl/isolate_pkg.sv
rtl/track_if.sv
rtl/write_gate.sv
rtl/read_gate.sv
rtl/isolation_tracker.sv
rtl/axi_isolate_top.sv
verif/tb_axi_isolate.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the AXI isolation gate testbench with Verilator and run it
# the run status comes from a search of sim.log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_axi_isolate -o sim_axi_isolate \
  && ./obj_dir/sim_axi_isolate > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "failures found in sim.log"; exit 1; } || exit 0
